// ==== logic/sdram_pkg.sv ====
/* sdram shared port definitions
   widths, queue entry and controller response records
   used by the request adapters, the queue and the controller */
package sdram_pkg;

    localparam int SDRAM_DW = 32;           // memory word width
    localparam int CLIENT_W = 1;            // tag width, two clients
    localparam int ENT_AW   = 16;           // entry address field, covers SDRAMW up to 16
    localparam int ENT_DW   = 16;           // entry write data field
    localparam int ENT_MW   = ENT_DW / 8;   // one enable per byte lane

    typedef logic [CLIENT_W-1:0] client_t;
    typedef logic [ENT_AW-1:0]   ent_addr_t;
    typedef logic [ENT_DW-1:0]   ent_data_t;
    typedef logic [ENT_MW-1:0]   ent_mask_t;

    // one queued request, built by the queue from an adapter's outputs
    typedef struct packed {
        client_t   client;  // which adapter asked
        logic      rnw;     // high for read
        ent_addr_t addr;    // word address, region offset already added
        ent_data_t wdata;
        ent_mask_t wmask;   // byte lanes to update on a write
    } rq_entry_t;

    // controller answer, broadcast to both adapters
    typedef struct packed {
        logic                valid;     // one cycle strobe
        client_t             client;
        logic                rnw;
        logic [SDRAM_DW-1:0] rdata;     // full stored word
    } rq_resp_t;

endpackage

// ==== logic/mem_rq.sv ====
/* chip select request adapter
   one request per rising edge of cs, address moved into the client region,
   data_ok held from the tagged response until cs drops */
`timescale 1ns/1ps

module mem_rq #(
    parameter int SDRAMW    = 10,
    parameter int AW        = 8,
    parameter int DW        = 16,
    parameter int CLIENT_ID = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [AW-1:0]         addr,
    input  logic [SDRAMW-1:0]     offset,     // region base, static during play
    input  logic                  addr_ok,    // cs from the cpu decoder
    input  logic                  wrin,       // high for a write cycle
    input  logic [DW-1:0]         wrdata,
    input  sdram_pkg::rq_resp_t   resp,
    output logic                  req,
    output logic                  req_rnw,
    output logic [SDRAMW-1:0]     sdram_addr,
    output logic [DW-1:0]         wdata,
    output logic                  data_ok,
    output logic [DW-1:0]         dout
);

    localparam sdram_pkg::client_t MY_TAG = sdram_pkg::client_t'(CLIENT_ID);

    logic [SDRAMW-1:0] addr_ext;
    logic              last_cs;
    logic              cs_posedge;
    logic              cs_negedge;
    logic              resp_hit;
    logic              start;

    assign addr_ext   = SDRAMW'(addr);      // zero extended cpu address
    assign cs_posedge = addr_ok && !last_cs;
    assign cs_negedge = !addr_ok && last_cs;
    assign resp_hit   = resp.valid && (resp.client == MY_TAG) && req; // our answer
    assign start      = cs_posedge && !resp_hit;

    // request and strobe state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_cs <= 1'b0;
            req     <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            last_cs <= addr_ok;
            if (cs_negedge) data_ok <= 1'b0;    // strobe ends with cs
            if (resp_hit) begin
                req     <= 1'b0;
                data_ok <= 1'b1;
            end else if (start) begin
                req     <= 1'b1;                // held until the response
                data_ok <= 1'b0;
            end
        end
    end

    // request payload and read data
    always_ff @(posedge clk) begin
        if (start) begin
            req_rnw    <= ~wrin;
            sdram_addr <= addr_ext + offset;    // move into client region
            wdata      <= wrdata;
        end
        if (resp_hit && resp.rnw) dout <= resp.rdata[DW-1:0];   // low lanes only
    end

endmodule

// ==== logic/rq_queue.sv ====
/* request queue
   round robin pick between two adapters, one outstanding request per client,
   accepted requests kept in order in a small circular fifo */
`timescale 1ns/1ps

module rq_queue #(
    parameter int DEPTH  = 4,
    parameter int SDRAMW = 10,
    parameter int DW     = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req0,
    input  logic                   rnw0,
    input  logic [SDRAMW-1:0]      addr0,
    input  logic [DW-1:0]          wdata0,
    input  logic                   req1,
    input  logic                   rnw1,
    input  logic [SDRAMW-1:0]      addr1,
    input  logic [DW-1:0]          wdata1,
    input  logic                   pop,        // controller took the head
    input  sdram_pkg::rq_resp_t    resp,
    output sdram_pkg::rq_entry_t   head,
    output logic                   entry_valid
);

    localparam int PW   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNTW = $clog2(DEPTH + 1);

    // byte lanes touched by a client write
    localparam sdram_pkg::ent_mask_t LANES = (DW == 8) ? sdram_pkg::ent_mask_t'(2'b01)
                                                       : sdram_pkg::ent_mask_t'(2'b11);

    sdram_pkg::rq_entry_t fifo [DEPTH];
    sdram_pkg::rq_entry_t new_ent;
    logic [1:0]           pend;       // request already queued or in service
    logic                 prio1;      // client 1 wins the next tie
    logic                 elig0;
    logic                 elig1;
    logic                 grant1;
    logic                 push;
    logic                 full;
    logic [PW-1:0]        rd_ptr;
    logic [PW-1:0]        wr_ptr;
    logic [CNTW-1:0]      count;

    function automatic sdram_pkg::rq_entry_t mk_entry(
        input sdram_pkg::client_t id,
        input logic               rnw,
        input logic [SDRAMW-1:0]  a,
        input logic [DW-1:0]      d
    );
        sdram_pkg::rq_entry_t e;
        e.client = id;
        e.rnw    = rnw;
        e.addr   = sdram_pkg::ent_addr_t'(a);
        e.wdata  = sdram_pkg::ent_data_t'(d);
        e.wmask  = LANES;
        return e;
    endfunction

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;   // wrap at DEPTH
    endfunction

    assign full   = (count == CNTW'(DEPTH));
    assign elig0  = req0 && !pend[0] && !full;
    assign elig1  = req1 && !pend[1] && !full;
    assign grant1 = elig1 && (!elig0 || prio1);     // tie goes to prio
    assign push   = elig0 || elig1;

    assign new_ent = grant1 ? mk_entry(sdram_pkg::client_t'(1), rnw1, addr1, wdata1)
                            : mk_entry(sdram_pkg::client_t'(0), rnw0, addr0, wdata0);

    assign head        = fifo[rd_ptr];
    assign entry_valid = (count != '0);

    // pending flags and arbitration order
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend  <= 2'b00;
            prio1 <= 1'b0;      // client 0 first after reset
        end else begin
            if (resp.valid) pend[resp.client] <= 1'b0;  // answered, may ask again
            if (push) pend[grant1] <= 1'b1;
            if (elig0 && elig1) prio1 <= ~grant1;       // alternate on contention
        end
    end

    // fifo pointers and fill level
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) fifo[wr_ptr] <= new_ent;
    end

endmodule

// ==== logic/sdram_ctrl.sv ====
/* sdram stand-in controller
   takes one queued entry at a time, reads after a fixed latency,
   merges writes by byte lane and answers every request with a tagged response */
`timescale 1ns/1ps

module sdram_ctrl #(
    parameter int SDRAMW = 10,
    parameter int LAT    = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  sdram_pkg::rq_entry_t   head,
    input  logic                   entry_valid,
    output logic                   pop,
    output sdram_pkg::rq_resp_t    resp
);

    localparam int CW = (LAT > 1) ? $clog2(LAT) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,    // counting read latency
        ST_RESP     // response valid this cycle
    } state_t;

    state_t                          state;
    logic [CW-1:0]                   cnt;
    sdram_pkg::rq_entry_t            cur;       // entry in service
    sdram_pkg::rq_entry_t            src;
    logic [sdram_pkg::SDRAM_DW-1:0]  mem [2**SDRAMW];
    logic [SDRAMW-1:0]               src_addr;
    logic [SDRAMW-1:0]               wr_addr;
    logic [sdram_pkg::SDRAM_DW-1:0]  merged;
    logic                            fire;
    sdram_pkg::client_t              rsp_client;
    logic                            rsp_rnw;
    logic [sdram_pkg::SDRAM_DW-1:0]  rsp_rdata;

    assign pop = (state == ST_IDLE) && entry_valid;     // only while idle

    // head while idle, latched entry afterwards
    assign src      = (state == ST_IDLE) ? head : cur;
    assign src_addr = src.addr[SDRAMW-1:0];
    assign wr_addr  = head.addr[SDRAMW-1:0];

    // writes and one-cycle reads answer straight from idle
    assign fire = (pop && (!head.rnw || LAT == 1)) ||
                  ((state == ST_READ) && (cnt == CW'(1)));

    // merge the enabled lanes, upper word lanes never touched
    always_comb begin
        merged = mem[wr_addr];
        for (int i = 0; i < sdram_pkg::ENT_MW; i++) begin
            if (head.wmask[i]) merged[8*i +: 8] = head.wdata[8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (pop && !head.rnw) mem[wr_addr] <= merged;
    end

    // service state machine
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        if (fire) begin
                            state <= ST_RESP;
                        end else begin
                            state <= ST_READ;
                            cnt   <= CW'(LAT - 1);  // cycles left before answer
                        end
                    end
                end
                ST_READ: begin
                    cnt <= cnt - 1'b1;
                    if (fire) state <= ST_RESP;
                end
                ST_RESP: state <= ST_IDLE;  // one cycle strobe
                default: state <= ST_IDLE;
            endcase
        end
    end

    // response payload, a write answers with the updated word
    always_ff @(posedge clk) begin
        if (pop) cur <= head;
        if (fire) begin
            rsp_client <= src.client;
            rsp_rnw    <= src.rnw;
            rsp_rdata  <= src.rnw ? mem[src_addr] : merged;
        end
    end

    assign resp = '{
        valid:  (state == ST_RESP),
        client: rsp_client,
        rnw:    rsp_rnw,
        rdata:  rsp_rdata
    };

endmodule

// ==== logic/mem_sys_top.sv ====
/* shared memory port top
   main and sound cpu adapters feeding one queue and one sdram controller */
`timescale 1ns/1ps

module mem_sys_top #(
    parameter int SDRAMW = 10,
    parameter int AW     = 8,
    parameter int DW     = 16,
    parameter int DEPTH  = 4,
    parameter int LAT    = 3
) (
    input  logic              clk,
    input  logic              rst,
    // main cpu
    input  logic [AW-1:0]     cpu0_addr,
    input  logic [SDRAMW-1:0] cpu0_offset,
    input  logic              cpu0_cs,
    input  logic              cpu0_wrin,
    input  logic [DW-1:0]     cpu0_wrdata,
    output logic              cpu0_data_ok,
    output logic [DW-1:0]     cpu0_dout,
    // sound cpu
    input  logic [AW-1:0]     cpu1_addr,
    input  logic [SDRAMW-1:0] cpu1_offset,
    input  logic              cpu1_cs,
    input  logic              cpu1_wrin,
    input  logic [DW-1:0]     cpu1_wrdata,
    output logic              cpu1_data_ok,
    output logic [DW-1:0]     cpu1_dout
);

    logic                  req0;
    logic                  rnw0;
    logic [SDRAMW-1:0]     addr0;
    logic [DW-1:0]         wdata0;
    logic                  req1;
    logic                  rnw1;
    logic [SDRAMW-1:0]     addr1;
    logic [DW-1:0]         wdata1;
    logic                  pop;
    logic                  entry_valid;
    sdram_pkg::rq_entry_t  head;
    sdram_pkg::rq_resp_t   resp;       // shared by both adapters

    mem_rq #(.SDRAMW(SDRAMW), .AW(AW), .DW(DW), .CLIENT_ID(0)) u_rq0 (
        .clk(clk), .rst(rst),
        .addr(cpu0_addr), .offset(cpu0_offset), .addr_ok(cpu0_cs),
        .wrin(cpu0_wrin), .wrdata(cpu0_wrdata), .resp(resp),
        .req(req0), .req_rnw(rnw0), .sdram_addr(addr0), .wdata(wdata0),
        .data_ok(cpu0_data_ok), .dout(cpu0_dout)
    );

    mem_rq #(.SDRAMW(SDRAMW), .AW(AW), .DW(DW), .CLIENT_ID(1)) u_rq1 (
        .clk(clk), .rst(rst),
        .addr(cpu1_addr), .offset(cpu1_offset), .addr_ok(cpu1_cs),
        .wrin(cpu1_wrin), .wrdata(cpu1_wrdata), .resp(resp),
        .req(req1), .req_rnw(rnw1), .sdram_addr(addr1), .wdata(wdata1),
        .data_ok(cpu1_data_ok), .dout(cpu1_dout)
    );

    rq_queue #(.DEPTH(DEPTH), .SDRAMW(SDRAMW), .DW(DW)) u_queue (
        .clk(clk), .rst(rst),
        .req0(req0), .rnw0(rnw0), .addr0(addr0), .wdata0(wdata0),
        .req1(req1), .rnw1(rnw1), .addr1(addr1), .wdata1(wdata1),
        .pop(pop), .resp(resp), .head(head), .entry_valid(entry_valid)
    );

    sdram_ctrl #(.SDRAMW(SDRAMW), .LAT(LAT)) u_ctrl (
        .clk(clk), .rst(rst),
        .head(head), .entry_valid(entry_valid),
        .pop(pop), .resp(resp)
    );

endmodule

// ==== sim/tb_mem_sys.sv ====
/* shared memory port testbench
   two random cpu clients against a byte lane reference model,
   strobe rule monitor and completion counts */
`timescale 1ns/1ps

module tb_mem_sys;

    localparam int SDRAMW     = 10;
    localparam int AW         = 8;
    localparam int DW         = 16;
    localparam int DEPTH      = 4;
    localparam int LAT        = 3;
    localparam int NTRANS     = 200;                    // per client
    localparam int NLANE      = DW / 8;                 // lanes a client write touches
    localparam int NWORD      = 2 ** SDRAMW;
    localparam int MAX_CYCLES = 2 * NTRANS * 2 * (LAT + 6) + 500;

    logic              clk;
    logic              rst;
    logic [AW-1:0]     addr   [2];
    logic [SDRAMW-1:0] offset [2];
    logic              cs     [2];
    logic              wrin   [2];
    logic [DW-1:0]     wrdata [2];
    logic              data_ok[2];
    logic [DW-1:0]     dout   [2];

    // pre-drawn stimulus, one row per client
    logic [AW-1:0]     addr_s [2][NTRANS];
    logic              wr_s   [2][NTRANS];
    logic [DW-1:0]     data_s [2][NTRANS];
    int                gap_s  [2][NTRANS];

    logic [31:0]       model  [NWORD];     // reference words
    logic [3:0]        known  [NWORD];     // lane written at least once
    logic [31-8*NLANE:0] upper [NWORD];    // lanes clients never reach
    integer            seed;
    int                data_errors;
    int                strobe_errors;
    int                count_errors;
    int                issued  [2];
    int                done    [2];
    int                rises   [2];
    int                checked [2];        // read lanes compared
    int                cycles;
    logic              prev_cs [2];
    logic              prev_dok[2];

    mem_sys_top #(
        .SDRAMW(SDRAMW), .AW(AW), .DW(DW), .DEPTH(DEPTH), .LAT(LAT)
    ) i_dut (
        .clk(clk), .rst(rst),
        .cpu0_addr(addr[0]), .cpu0_offset(offset[0]), .cpu0_cs(cs[0]),
        .cpu0_wrin(wrin[0]), .cpu0_wrdata(wrdata[0]),
        .cpu0_data_ok(data_ok[0]), .cpu0_dout(dout[0]),
        .cpu1_addr(addr[1]), .cpu1_offset(offset[1]), .cpu1_cs(cs[1]),
        .cpu1_wrin(wrin[1]), .cpu1_wrdata(wrdata[1]),
        .cpu1_data_ok(data_ok[1]), .cpu1_dout(dout[1])
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    // update the model on a write, compare known lanes on a read
    task automatic check_result(input int id, input int t);
        int wa;
        wa = (int'(offset[id]) + int'(addr_s[id][t])) % NWORD;
        done[id]++;
        if (wr_s[id][t]) begin
            for (int i = 0; i < NLANE; i++) begin
                model[wa][8*i +: 8] = data_s[id][t][8*i +: 8];
                known[wa][i] = 1'b1;
            end
        end else begin
            for (int i = 0; i < NLANE; i++) begin
                if (known[wa][i]) checked[id]++;
                if (known[wa][i] && dout[id][8*i +: 8] !== model[wa][8*i +: 8]) begin
                    data_errors++;
                    $display("Fail at time %0t: client %0d word %0h lane %0d got %0h, want %0h",
                             $time, id, wa, i, dout[id][8*i +: 8], model[wa][8*i +: 8]);
                end
            end
        end
    endtask

    // one cpu: raise cs, wait for data_ok, drop cs, idle a little
    task automatic run_client(input int id);
        for (int t = 0; t < NTRANS; t++) begin
            repeat (gap_s[id][t]) @(posedge clk);
            @(posedge clk);
            addr[id]   <= addr_s[id][t];
            wrin[id]   <= wr_s[id][t];
            wrdata[id] <= data_s[id][t];
            cs[id]     <= 1'b1;
            issued[id]++;
            @(negedge clk);
            while (!data_ok[id]) @(negedge clk);    // watchdog bounds this
            check_result(id, t);
            @(posedge clk);
            cs[id] <= 1'b0;
        end
    endtask

    // strobe rule, sampled mid cycle where everything is settled
    always @(negedge clk) begin
        if (!rst) begin
            for (int n = 0; n < 2; n++) begin
                if (data_ok[n] && !prev_dok[n]) begin
                    rises[n]++;
                    if (!cs[n] || !prev_cs[n]) begin
                        strobe_errors++;
                        $display("Client %0d: data_ok rose at %0t outside a chip select cycle",
                                 n, $time);
                    end
                end
                if (data_ok[n] && !cs[n] && !prev_cs[n]) begin
                    strobe_errors++;
                    $display("Client %0d: data_ok still high at time %0t a cycle after cs fell",
                             n, $time);
                end
                if (!data_ok[n] && prev_dok[n] && prev_cs[n]) begin
                    strobe_errors++;
                    $display("Client %0d: data_ok dropped at time %0t while cs was still high",
                             n, $time);
                end
                prev_cs[n]  = cs[n];
                prev_dok[n] = data_ok[n];
            end
        end
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles", cycles);
        $display("client 0 finished %0d of %0d, client 1 finished %0d of %0d",
                 done[0], NTRANS, done[1], NTRANS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int r;
        seed          = 12019;
        data_errors   = 0;
        strobe_errors = 0;
        count_errors  = 0;
        rst           = 1'b1;
        offset[0]     = SDRAMW'(0);
        offset[1]     = SDRAMW'(512);   // regions do not overlap
        for (int n = 0; n < 2; n++) begin
            addr[n]     = '0;
            cs[n]       = 1'b0;
            wrin[n]     = 1'b0;
            wrdata[n]   = '0;
            issued[n]   = 0;
            done[n]     = 0;
            rises[n]    = 0;
            checked[n]  = 0;
            prev_cs[n]  = 1'b0;
            prev_dok[n] = 1'b0;
        end
        for (int i = 0; i < NWORD; i++) begin
            model[i] = '0;
            known[i] = '0;
        end
        // small address window so reads often hit earlier writes
        for (int n = 0; n < 2; n++) begin
            for (int t = 0; t < NTRANS; t++) begin
                r = $random(seed);
                addr_s[n][t] = AW'(r & 31);
                wr_s[n][t]   = r[8];
                gap_s[n][t]  = (r >> 12) & 3;
                data_s[n][t] = DW'($random(seed));
            end
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < NWORD; i++) upper[i] = i_dut.u_ctrl.mem[i][31:8*NLANE];
        fork
            run_client(0);
            run_client(1);
        join
        repeat (4) @(posedge clk);
        for (int n = 0; n < 2; n++) begin
            if (rises[n] != issued[n]) begin    // one strobe per issued transaction
                count_errors++;
                $display("Client %0d: issued %0d, finished %0d, data_ok strobes %0d",
                         n, issued[n], done[n], rises[n]);
            end
            if (checked[n] == 0) begin
                count_errors++;
                $display("Client %0d: no read ever returned previously written data", n);
            end
        end
        for (int i = 0; i < NWORD; i++) begin
            if (i_dut.u_ctrl.mem[i][31:8*NLANE] !== upper[i]) begin
                count_errors++;
                $display("Word %0h: lanes above the client width were changed", i);
            end
        end
        $display("Errors: data %0d, strobe %0d, count %0d (lanes checked %0d and %0d)",
                 data_errors, strobe_errors, count_errors, checked[0], checked[1]);
        if (data_errors + strobe_errors + count_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
logic/sdram_pkg.sv
logic/mem_rq.sv
logic/rq_queue.sv
logic/sdram_ctrl.sv
logic/mem_sys_top.sv
sim/tb_mem_sys.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the shared memory port testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_mem_sys -f flist.f -o tb_mem_sys > build.log 2>&1 \
    || { cat build.log; echo "Build error, see build.log"; exit 1; }
./obj_dir/tb_mem_sys > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || { echo "Run ended without a result"; exit 1; }
exit 0
